/* hw/milStdPkg.sv */
// MIL-STD-1553 word format shared by the receive path.
// Only the receive side is described; no transmit encodings are held here.
package milStdPkg;

	localparam int wordBits = 16;                 // Payload bits per 1553 word.
	localparam int entryBits = wordBits + 2;      // Type tag plus payload.

	// Half-bits in the decode window: 2 prev, 6 sync, 32 content, 2 parity, 3 trail.
	localparam int windowLen = 45;

	localparam logic [5:0] syncServ = 6'b111000;  // Command/status sync.
	localparam logic [5:0] syncData = 6'b000111;  // Data word sync.

	typedef logic [wordBits-1:0] milWordT;

	typedef enum logic [1:0] {
		wServ    = 2'd0,
		wServErr = 2'd1,
		wData    = 2'd2,
		wDataErr = 2'd3
	} milTypeT;

	// Type in the upper two bits, payload below.
	typedef logic [entryBits-1:0] milEntryT;

endpackage

/* hw/milRegPkg.sv */
// Wishbone register map of the 1553 receiver.
// Word addressed; all registers are 32 bits wide, unused bits read as 0.
package milRegPkg;

	typedef logic [1:0]  wbAdrT;
	typedef logic [31:0] wbDatT;

	localparam wbAdrT regCtrl   = 2'd0;
	localparam wbAdrT regStatus = 2'd1;
	localparam wbAdrT regData   = 2'd2;   // Read pops the FIFO head.

	// Control register.
	localparam int ctrlEnable        = 0;
	localparam int ctrlClearOverflow = 1;   // Write 1 to clear, self clearing.

	// Status register.
	localparam int statusNotEmpty = 0;
	localparam int statusOverflow = 1;
	localparam int statusBusy     = 2;
	localparam int statusCountLsb = 8;
	localparam int statusCountMsb = 11;

endpackage

/* hw/milInputFilter.sv */
// Glitch filter for one receive line from the bus transceiver.
// The newest of three samples comes straight out of the synchronizer flop.
// Latency from pin to output is 2 clocks; single-clock pulses never pass.
`timescale 1ns/1ps

module milInputFilter (
	input  logic clk,
	input  logic arstN,
	input  logic line,
	output logic filtered
);

	logic       syncQ;
	logic [1:0] history;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			syncQ   <= 1'b0;
			history <= '0;
		end else begin
			syncQ   <= line;
			history <= {history[0], syncQ};
		end
	end

	// Two of three samples decide the level.
	assign filtered = (syncQ & history[0])
		| (syncQ & history[1])
		| (history[0] & history[1]);

endmodule

/* hw/milBitTimer.sv */
// Half-bit sampling strobe recovered from the Manchester edges.
// halfBitCycles must be 4 or more; the strobe lands mid half-bit
// as long as the transmitter clock stays close to the local one.
`timescale 1ns/1ps

module milBitTimer #(
	parameter int halfBitCycles = 50
) (
	input  logic clk,
	input  logic arstN,
	input  logic line,
	output logic sampleStrobe
);

	localparam int cntW = $clog2(halfBitCycles);
	localparam logic [cntW-1:0] lastPhase = cntW'(halfBitCycles - 1);
	localparam logic [cntW-1:0] midPhase  = cntW'(halfBitCycles / 2);

	logic            lineQ;
	logic            lineEdge;
	logic [cntW-1:0] phaseCnt;

	assign lineEdge = line ^ lineQ;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			lineQ    <= 1'b0;
			phaseCnt <= '0;
		end else begin
			lineQ <= line;
			if (lineEdge)
				phaseCnt <= midPhase;       // Resync on every transition.
			else if (phaseCnt == lastPhase)
				phaseCnt <= '0;
			else
				phaseCnt <= phaseCnt + 1'b1;
		end
	end

	assign sampleStrobe = (phaseCnt == '0);

	// Phase must stay inside one half-bit period.
	phaseRange: assert property (@(posedge clk) disable iff (!arstN)
		phaseCnt <= lastPhase);

endmodule

/* hw/milWordDecoder.sv */
// Manchester word recognizer working on a 45 half-bit sliding window.
// Data bits go MSB first; the bit value is the first half of each pair.
// Words with a broken pair are not reported at all; parity errors are flagged.
`timescale 1ns/1ps

module milWordDecoder (
	input  logic                clk,
	input  logic                arstN,
	input  logic                line,
	input  logic                sampleStrobe,
	output logic                wordValid,
	output milStdPkg::milTypeT  wordType,
	output milStdPkg::milWordT  wordData
);

	localparam int winLen = milStdPkg::windowLen;
	localparam int syncLsb = winLen - 8;
	localparam int contentLsb = 5;

	logic [winLen-1:0] window;
	logic [1:0]        prevHalf;
	logic [5:0]        syncField;
	logic [31:0]       content;
	logic [1:0]        parityPair;
	logic [2:0]        trail;
	logic              pairsOk;
	logic              trailOk;
	logic              parityErr;
	logic              isServ;
	logic              isData;
	logic              match;
	logic              matchQ;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			window <= '0;
			matchQ <= 1'b0;
		end else begin
			if (sampleStrobe)
				window <= {window[winLen-2:0], line};
			matchQ <= match;
		end
	end

	assign prevHalf   = window[winLen-1 -: 2];
	assign syncField  = window[syncLsb +: 6];
	assign content    = window[contentLsb +: 32];
	assign parityPair = window[4:3];
	assign trail      = window[2:0];

	always_comb begin
		pairsOk = ^parityPair;
		for (int i = 0; i < 16; i++) begin
			wordData[i] = content[2*i + 1];
			pairsOk = pairsOk & (content[2*i + 1] ^ content[2*i]);
		end
	end

	assign trailOk   = (trail == 3'b000) || (trail == 3'b111);
	assign parityErr = ~^{wordData, parityPair[1]};   // Odd parity expected.
	assign isServ    = (syncField == milStdPkg::syncServ);
	assign isData    = (syncField == milStdPkg::syncData) && (prevHalf != 2'b00);
	assign match     = pairsOk && trailOk && (isServ || isData);

	always_comb begin
		if (isServ)
			wordType = parityErr ? milStdPkg::wServErr : milStdPkg::wServ;
		else
			wordType = parityErr ? milStdPkg::wDataErr : milStdPkg::wData;
	end

	assign wordValid = match & ~matchQ;   // One pulse per matching window.

	singlePulse: assert property (@(posedge clk) disable iff (!arstN)
		wordValid |=> !wordValid);

endmodule

/* hw/milRxSequencer.sv */
// Receive control: opens the line to the decoder and stores decoded words.
// A word that meets a full FIFO is lost and sets the sticky overflow flag.
`timescale 1ns/1ps

module milRxSequencer (
	input  logic                clk,
	input  logic                arstN,
	input  logic                enable,
	input  logic                clearOverflow,
	input  logic                wordValid,
	input  milStdPkg::milTypeT  wordType,
	input  milStdPkg::milWordT  wordData,
	input  logic                full,
	output logic                grant,
	output logic                fifoPush,
	output milStdPkg::milEntryT pushEntry,
	output logic                overflow
);

	typedef enum logic [1:0] {
		sOff,
		sListen,
		sStore,
		sDrop
	} seqStateT;

	seqStateT state;
	logic     dropNow;

	assign dropNow = (state == sListen) && wordValid && full;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state    <= sOff;
			overflow <= 1'b0;
		end else begin
			case (state)
				sOff:    if (enable && !wordValid) state <= sListen;
				sListen: begin
					if (wordValid)
						state <= full ? sDrop : sStore;
					else if (!enable)
						state <= sOff;
				end
				default: state <= enable ? sListen : sOff;   // sStore and sDrop.
			endcase

			if (dropNow)
				overflow <= 1'b1;    // Visible together with sDrop.
			else if (clearOverflow)
				overflow <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (state == sListen && wordValid)
			pushEntry <= {wordType, wordData};
	end

	assign grant    = (state != sOff);
	assign fifoPush = (state == sStore);

	noPushWhenFull: assert property (@(posedge clk) disable iff (!arstN)
		!(fifoPush && full));

endmodule

/* hw/milWordFifo.sv */
// Register-array FIFO of decoded 1553 words.
// fifoDepth must be a power of two; head entry is shown without a read delay.
`timescale 1ns/1ps

module milWordFifo #(
	parameter int fifoDepth = 8
) (
	input  logic                           clk,
	input  logic                           arstN,
	input  logic                           push,
	input  milStdPkg::milEntryT            pushEntry,
	input  logic                           pop,
	output milStdPkg::milEntryT            headEntry,
	output logic                           empty,
	output logic                           full,
	output logic [$clog2(fifoDepth):0]     count
);

	localparam int ptrW = $clog2(fifoDepth);
	localparam int countW = ptrW + 1;

	milStdPkg::milEntryT mem [fifoDepth];
	logic [ptrW-1:0]     wrPtr;
	logic [ptrW-1:0]     rdPtr;
	logic                doPush;
	logic                doPop;

	assign doPush = push && !full;
	assign doPop  = pop && !empty;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (doPush)
			mem[wrPtr] <= pushEntry;
	end

	assign headEntry = mem[rdPtr];
	assign empty     = (count == '0);
	assign full      = (count == countW'(fifoDepth));

	noPopWhenEmpty: assert property (@(posedge clk) disable iff (!arstN)
		!(pop && empty));

endmodule

/* hw/milRxWishbone.sv */
// Wishbone classic slave for the receiver registers; ack one clock after request.
// fifoDepth must be 8 or less so the fill count fits its 4-bit status field.
// No stall and no error reply; reads of unused addresses return 0.
`timescale 1ns/1ps

module milRxWishbone #(
	parameter int fifoDepth = 8
) (
	input  logic                        clk,
	input  logic                        arstN,
	input  logic                        cyc,
	input  logic                        stb,
	input  logic                        we,
	input  milRegPkg::wbAdrT            adr,
	input  milRegPkg::wbDatT            datIn,
	input  logic                        overflow,
	input  logic                        busy,
	input  logic [$clog2(fifoDepth):0]  count,
	input  logic                        empty,
	input  milStdPkg::milEntryT         headEntry,
	output logic                        ack,
	output milRegPkg::wbDatT            datOut,
	output logic                        enable,
	output logic                        clearOverflow,
	output logic                        fifoPop
);

	localparam int countW = $clog2(fifoDepth) + 1;
	localparam int fieldW = milRegPkg::statusCountMsb - milRegPkg::statusCountLsb + 1;

	logic             request;
	logic             ctrlWrite;
	logic [fieldW-1:0] countField;
	milRegPkg::wbDatT readData;

	assign request   = cyc && stb && !ack;
	assign ctrlWrite = request && we && (adr == milRegPkg::regCtrl);

	always_comb begin
		countField = '0;
		countField[countW-1:0] = count;
		readData = '0;
		case (adr)
			milRegPkg::regCtrl: readData[milRegPkg::ctrlEnable] = enable;
			milRegPkg::regStatus: begin
				readData[milRegPkg::statusNotEmpty] = !empty;
				readData[milRegPkg::statusOverflow] = overflow;
				readData[milRegPkg::statusBusy]     = busy;
				readData[milRegPkg::statusCountMsb:milRegPkg::statusCountLsb] = countField;
			end
			milRegPkg::regData: if (!empty) readData = milRegPkg::wbDatT'(headEntry);
			default: readData = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ack           <= 1'b0;
			enable        <= 1'b0;
			clearOverflow <= 1'b0;
			fifoPop       <= 1'b0;
		end else begin
			ack           <= request;
			clearOverflow <= ctrlWrite && datIn[milRegPkg::ctrlClearOverflow];
			fifoPop       <= request && !we && (adr == milRegPkg::regData) && !empty;
			if (ctrlWrite)
				enable <= datIn[milRegPkg::ctrlEnable];
		end
	end

	always_ff @(posedge clk) begin
		if (request)
			datOut <= readData;   // Held until the next request.
	end

	singleAck: assert property (@(posedge clk) disable iff (!arstN)
		ack |=> !ack);

endmodule

/* hw/milRxTop.sv */
// MIL-STD-1553 bus receiver with a Wishbone classic host port.
// halfBitCycles sets the bit rate (50 gives 1 Mbit/s at 100 MHz).
// No address filtering and no response-time checks are done.
`timescale 1ns/1ps

module milRxTop #(
	parameter int halfBitCycles = 50,
	parameter int fifoDepth = 8
) (
	input  logic             clk,
	input  logic             arstN,
	input  logic             rxIn,
	input  logic             rxInN,
	input  logic             cyc,
	input  logic             stb,
	input  logic             we,
	input  milRegPkg::wbAdrT adr,
	input  milRegPkg::wbDatT datIn,
	output logic             ack,
	output milRegPkg::wbDatT datOut
);

	logic                         lineData;
	logic                         busy;
	logic                         grant;
	logic                         lineGated;
	logic                         sampleStrobe;
	logic                         wordValid;
	milStdPkg::milTypeT           wordType;
	milStdPkg::milWordT           wordData;
	logic                         fifoPush;
	milStdPkg::milEntryT          pushEntry;
	logic                         fifoPop;
	milStdPkg::milEntryT          headEntry;
	logic                         empty;
	logic                         full;
	logic [$clog2(fifoDepth):0]   count;
	logic                         enable;
	logic                         clearOverflow;
	logic                         overflow;

	milInputFilter uDataFilter (.clk, .arstN, .line(rxIn), .filtered(lineData));
	milInputFilter uBusyFilter (.clk, .arstN, .line(rxIn | rxInN), .filtered(busy));

	assign lineGated = grant ? lineData : 1'b0;   // Decoder sees idle while off.

	milBitTimer #(.halfBitCycles(halfBitCycles)) uBitTimer (
		.clk, .arstN, .line(lineGated), .sampleStrobe
	);

	milWordDecoder uDecoder (
		.clk, .arstN, .line(lineGated), .sampleStrobe, .wordValid, .wordType, .wordData
	);

	milRxSequencer uSequencer (
		.clk, .arstN, .enable, .clearOverflow, .wordValid, .wordType, .wordData,
		.full, .grant, .fifoPush, .pushEntry, .overflow
	);

	milWordFifo #(.fifoDepth(fifoDepth)) uFifo (
		.clk, .arstN, .push(fifoPush), .pushEntry, .pop(fifoPop),
		.headEntry, .empty, .full, .count
	);

	milRxWishbone #(.fifoDepth(fifoDepth)) uWishbone (
		.clk, .arstN, .cyc, .stb, .we, .adr, .datIn, .overflow, .busy, .count,
		.empty, .headEntry, .ack, .datOut, .enable, .clearOverflow, .fifoPop
	);

endmodule

/* sim/tbClock.sv */
// Clock and reset source for the receiver testbench.
// 10 ns period; arstN is released on a rising edge after resetCycles edges.
`timescale 1ns/1ps

module tbClock #(
	parameter int resetCycles = 5
) (
	output logic clk,
	output logic arstN
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		arstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		arstN <= 1'b1;
	end

endmodule

/* sim/milRxTb.sv */
// Testbench for the 1553 receiver, run with a short half-bit and a 4-deep FIFO.
// Stored words are checked in order against a reference model of the decoder.
`timescale 1ns/1ps

module milRxTb;

	localparam int halfBitCycles = 8;
	localparam int fifoDepth = 4;
	localparam int timeoutCycles = 40 * 40 * halfBitCycles + 2000;   // 40 word times.

	logic             clk;
	logic             arstN;
	logic             rxIn;
	logic             rxInN;
	logic             cyc;
	logic             stb;
	logic             we;
	milRegPkg::wbAdrT adr;
	milRegPkg::wbDatT datIn;
	logic             ack;
	milRegPkg::wbDatT datOut;

	integer              seed = 32'h19aa;
	int                  cycleCount = 0;
	bit                  busLock = 1'b0;
	bit                  drainOn = 1'b0;
	milStdPkg::milEntryT expQ[$];        // Words the DUT should store, oldest first.
	milStdPkg::milWordT  msgWord[8];
	bit                  msgIsData[8];
	bit                  msgParBad[8];
	int                  msgPairBad[8];     // Index of the broken bit pair, or -1.
	int                  msgLen = 0;

	tbClock #(.resetCycles(5)) uClock (.clk, .arstN);

	milRxTop #(.halfBitCycles(halfBitCycles), .fifoDepth(fifoDepth)) u_dut (
		.clk, .arstN, .rxIn, .rxInN, .cyc, .stb, .we, .adr, .datIn, .ack, .datOut
	);

	task automatic failRun(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected)
			failRun($sformatf("error %s got 0x%h expected 0x%h", name, got, expected));
	endtask

	// Type follows from the ones in payload plus sent parity bit.
	function automatic milStdPkg::milEntryT expectEntry(input bit isData,
			input milStdPkg::milWordT payload, input bit parityBad);
		int                 ones;
		bit                 parityBit;
		bit                 err;
		milStdPkg::milTypeT kind;
		parityBit = ~(^payload) ^ parityBad;
		ones = parityBit ? 1 : 0;
		for (int i = 0; i < 16; i++)
			ones = ones + (payload[i] ? 1 : 0);
		err = (ones % 2) == 0;
		if (isData)
			kind = err ? milStdPkg::wDataErr : milStdPkg::wData;
		else
			kind = err ? milStdPkg::wServErr : milStdPkg::wServ;
		return {kind, payload};
	endfunction

	task automatic busTransfer(input bit write, input milRegPkg::wbAdrT addr,
			input milRegPkg::wbDatT wdata, output milRegPkg::wbDatT rdata);
		while (busLock) @(posedge clk);
		busLock = 1'b1;
		@(posedge clk);
		cyc   <= 1'b1;
		stb   <= 1'b1;
		we    <= write;
		adr   <= addr;
		datIn <= wdata;
		do @(posedge clk); while (!ack);
		rdata = datOut;
		cyc <= 1'b0;
		stb <= 1'b0;
		we  <= 1'b0;
		busLock = 1'b0;
	endtask

	task automatic readReg(input milRegPkg::wbAdrT addr, output milRegPkg::wbDatT data);
		busTransfer(1'b0, addr, '0, data);
	endtask

	task automatic writeReg(input milRegPkg::wbAdrT addr, input milRegPkg::wbDatT data);
		milRegPkg::wbDatT unused;
		busTransfer(1'b1, addr, data, unused);
	endtask

	task automatic driveHalf(input bit level);
		@(posedge clk);
		rxIn  <= level;
		rxInN <= !level;
		repeat (halfBitCycles - 1) @(posedge clk);
	endtask

	task automatic addWord(input bit isData, input bit parityBad, input int pairBad);
		msgWord[msgLen]    = milStdPkg::milWordT'($random(seed));
		msgIsData[msgLen]  = isData;
		msgParBad[msgLen]  = parityBad;
		msgPairBad[msgLen] = pairBad;
		msgLen = msgLen + 1;
	endtask

	task automatic sendWord(input int k);
		bit parityBit;
		bit first;
		parityBit = ~(^msgWord[k]) ^ msgParBad[k];
		if (msgPairBad[k] < 0)
			expQ.push_back(expectEntry(msgIsData[k], msgWord[k], msgParBad[k]));
		for (int i = 0; i < 6; i++)
			driveHalf(msgIsData[k] ? (i >= 3) : (i < 3));
		for (int i = 15; i >= 0; i--) begin
			first = msgWord[k][i];
			driveHalf(first);
			driveHalf((i == msgPairBad[k]) ? first : !first);
		end
		driveHalf(parityBit);
		driveHalf(!parityBit);
	endtask

	// Words back to back, then both pins idle low for eight half-bits.
	task automatic sendMessage();
		for (int k = 0; k < msgLen; k++)
			sendWord(k);
		@(posedge clk);
		rxIn  <= 1'b0;
		rxInN <= 1'b0;
		repeat (8 * halfBitCycles - 1) @(posedge clk);
		msgLen = 0;
	endtask

	task automatic waitDrained();
		while (expQ.size() != 0) @(posedge clk);
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles)
			failRun($sformatf("the run did not finish within %0d clock cycles",
				timeoutCycles));
	end

	// Pops every stored word and compares it with the oldest expected entry.
	initial begin : compareWords
		milRegPkg::wbDatT    status;
		milRegPkg::wbDatT    word;
		milStdPkg::milEntryT expected;
		@(posedge arstN);
		forever begin
			if (!drainOn) begin
				@(posedge clk);
			end else begin
				readReg(milRegPkg::regStatus, status);
				if (status[milRegPkg::statusNotEmpty]) begin
					readReg(milRegPkg::regData, word);
					if (expQ.size() == 0)
						failRun($sformatf("the FIFO held word 0x%h that was never sent", word));
					expected = expQ.pop_front();
					checkValue("datOut", word, milRegPkg::wbDatT'(expected));
				end
				repeat (2) @(posedge clk);   // Gives the main sequence a turn on the bus.
			end
		end
	end

	initial begin : mainSequence
		milRegPkg::wbDatT value;
		rxIn  = 1'b0;
		rxInN = 1'b0;
		cyc   = 1'b0;
		stb   = 1'b0;
		we    = 1'b0;
		adr   = '0;
		datIn = '0;
		@(posedge arstN);
		repeat (2) @(posedge clk);

		writeReg(milRegPkg::regCtrl, 32'h1);
		drainOn = 1'b1;
		addWord(1'b0, 1'b0, -1);
		fork
			sendMessage();
			begin
				repeat (10 * halfBitCycles) @(posedge clk);
				readReg(milRegPkg::regStatus, value);
				checkValue("busy", 32'(value[milRegPkg::statusBusy]), 32'd1);
			end
		join
		waitDrained();

		addWord(1'b0, 1'b0, -1);
		addWord(1'b1, 1'b0, -1);
		addWord(1'b1, 1'b0, -1);
		sendMessage();
		waitDrained();
		addWord(1'b0, 1'b1, -1);
		addWord(1'b1, 1'b1, -1);
		addWord(1'b1, 1'b1, -1);
		sendMessage();
		waitDrained();

		addWord(1'b0, 1'b0, int'($random(seed) & 15));   // Broken pair, never stored.
		sendMessage();
		addWord(1'b0, 1'b0, -1);
		sendMessage();
		waitDrained();

		drainOn = 1'b0;
		addWord(1'b0, 1'b0, -1);
		repeat (5) addWord(1'b1, 1'b0, -1);
		sendMessage();
		while (expQ.size() > fifoDepth)
			void'(expQ.pop_back());
		readReg(milRegPkg::regStatus, value);
		checkValue("overflow", 32'(value[milRegPkg::statusOverflow]), 32'd1);
		checkValue("count", 32'(value[milRegPkg::statusCountMsb:milRegPkg::statusCountLsb]),
			32'(fifoDepth));
		writeReg(milRegPkg::regCtrl, 32'h3);
		readReg(milRegPkg::regStatus, value);
		checkValue("overflow", 32'(value[milRegPkg::statusOverflow]), 32'd0);
		drainOn = 1'b1;
		waitDrained();
		readReg(milRegPkg::regData, value);
		checkValue("datOut", value, 32'd0);

		drainOn = 1'b0;
		writeReg(milRegPkg::regCtrl, 32'h0);
		addWord(1'b0, 1'b0, -1);
		sendMessage();
		readReg(milRegPkg::regStatus, value);
		checkValue("notEmpty", 32'(value[milRegPkg::statusNotEmpty]), 32'd0);
		expQ.delete();
		writeReg(milRegPkg::regCtrl, 32'h1);
		drainOn = 1'b1;
		addWord(1'b0, 1'b0, -1);
		sendMessage();
		waitDrained();

		$display(">>> PASS");
		$finish;
	end

endmodule

/* verilog.f */
hw/milStdPkg.sv
hw/milRegPkg.sv
hw/milInputFilter.sv
hw/milBitTimer.sv
hw/milWordDecoder.sv
hw/milRxSequencer.sv
hw/milWordFifo.sv
hw/milRxWishbone.sv
hw/milRxTop.sv
sim/tbClock.sv
sim/milRxTb.sv

/* Makefile */
TOOL     = verilator
TOP      = milRxTb
FILELIST = verilog.f
FLAGS    = --binary --timing --assert -j 0
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
